// ==== project.f ====
logic/rvfi_check_pkg.sv
logic/rvfi_retire_buffer.sv
logic/insn_sext_checker.sv
logic/insn_minmax_checker.sv
logic/spec_compare.sv
logic/rvfi_insn_monitor.sv
tb/tb_rvfi_insn_monitor.sv

// ==== tb/tb_rvfi_insn_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the retirement monitor. Each table row becomes one RVFI packet
// whose report is built from the instruction rules, with at most one field broken.
module tb_rvfi_insn_monitor import rvfi_check_pkg::*; ();

    localparam int    CLK_PERIOD   = 20;
    localparam int    TIMEOUT      = 50;
    localparam int    STALL_CYCLES = 8;
    localparam xlen_t LCG_SEED     = 32'h3544a86a;
    localparam int    NO_CORRUPT   = -1;

    localparam insn_t OP_SEXTB = 32'h60401013;
    localparam insn_t OP_SEXTH = 32'h60501013;
    localparam insn_t OP_MIN   = 32'h0a004033;
    localparam insn_t OP_MINU  = 32'h0a005033;
    localparam insn_t OP_MAX   = 32'h0a006033;
    localparam insn_t OP_MAXU  = 32'h0a007033;
    localparam insn_t OP_ADD   = 32'h00000033;

    typedef struct packed {
        logic [7:0]  row;
        logic        checked;
        field_mask_t fields;
        xlen_t       pc;
        logic [31:0] cycle;
        logic        check_lat;
    } expect_t;

    logic        clock = 1'b0;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    insn_t       rvfi_insn;
    xlen_t       rvfi_pc_rdata;
    reg_addr_t   rvfi_rs1_addr;
    reg_addr_t   rvfi_rs2_addr;
    xlen_t       rvfi_rs1_rdata;
    xlen_t       rvfi_rs2_rdata;
    reg_addr_t   rvfi_rd_addr;
    xlen_t       rvfi_rd_wdata;
    xlen_t       rvfi_pc_wdata;
    logic        rvfi_trap;
    logic        verdict_valid;
    logic        verdict_ready;
    logic        verdict_checked;
    field_mask_t verdict_fields;
    xlen_t       verdict_pc;

    insn_t       row_insn [32];
    xlen_t       row_rs1 [32];
    xlen_t       row_rs2 [32];
    int          row_corrupt [32];
    bit          row_random [32];
    int          n_rows = 0;

    expect_t     sb_q [$];
    xlen_t       lcg_state = LCG_SEED;
    int          cycle_count = 0;
    int          accept_count = 0;
    int          errors = 0;
    int          tests = 0;
    bit          timed_out = 1'b0;

    // The report a correct core would give, after corruption, and its verdict.
    reg_addr_t   rep_rs1_addr;
    reg_addr_t   rep_rs2_addr;
    reg_addr_t   rep_rd_addr;
    xlen_t       rep_rd_wdata;
    xlen_t       rep_pc_wdata;
    logic        rep_trap;
    logic        exp_checked;
    field_mask_t exp_fields;

    rvfi_insn_monitor u_dut (
        .clock           (clock),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .rvfi_insn       (rvfi_insn),
        .rvfi_pc_rdata   (rvfi_pc_rdata),
        .rvfi_rs1_addr   (rvfi_rs1_addr),
        .rvfi_rs2_addr   (rvfi_rs2_addr),
        .rvfi_rs1_rdata  (rvfi_rs1_rdata),
        .rvfi_rs2_rdata  (rvfi_rs2_rdata),
        .rvfi_rd_addr    (rvfi_rd_addr),
        .rvfi_rd_wdata   (rvfi_rd_wdata),
        .rvfi_pc_wdata   (rvfi_pc_wdata),
        .rvfi_trap       (rvfi_trap),
        .verdict_valid   (verdict_valid),
        .verdict_ready   (verdict_ready),
        .verdict_checked (verdict_checked),
        .verdict_fields  (verdict_fields),
        .verdict_pc      (verdict_pc)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic xlen_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic insn_t encode(input insn_t base, input int rd, input int rs1,
                                     input int rs2);
        return base | (insn_t'(rs2) << 20) | (insn_t'(rs1) << 15) | (insn_t'(rd) << 7);
    endfunction

    task automatic add_row(input insn_t insn, input xlen_t rs1, input xlen_t rs2,
                           input int corrupt, input bit random);
        row_insn[n_rows]    = insn;
        row_rs1[n_rows]     = rs1;
        row_rs2[n_rows]     = rs2;
        row_corrupt[n_rows] = corrupt;
        row_random[n_rows]  = random;
        n_rows++;
    endtask

    task automatic load_table();
        // Sign bit set and clear for both widths, then a write to x0.
        add_row(encode(OP_SEXTB, 5, 6, 0), 32'h000000f0, 32'h0, NO_CORRUPT, 1'b0);
        add_row(encode(OP_SEXTB, 5, 6, 0), 32'h1234567f, 32'h0, NO_CORRUPT, 1'b0);
        add_row(encode(OP_SEXTH, 10, 11, 0), 32'h00008001, 32'h0, NO_CORRUPT, 1'b0);
        add_row(encode(OP_SEXTH, 10, 11, 0), 32'habcd7ffe, 32'h0, NO_CORRUPT, 1'b0);
        add_row(encode(OP_SEXTB, 0, 6, 0), 32'h00000080, 32'h0, NO_CORRUPT, 1'b0);
        // Minus one against one orders one way signed and the other unsigned.
        add_row(encode(OP_MIN, 7, 8, 9), 32'hffffffff, 32'h00000001, NO_CORRUPT, 1'b0);
        add_row(encode(OP_MINU, 7, 8, 9), 32'hffffffff, 32'h00000001, NO_CORRUPT, 1'b0);
        add_row(encode(OP_MAX, 7, 8, 9), 32'hffffffff, 32'h00000001, NO_CORRUPT, 1'b0);
        add_row(encode(OP_MAXU, 7, 8, 9), 32'hffffffff, 32'h00000001, NO_CORRUPT, 1'b0);
        add_row(encode(OP_MAX, 0, 8, 9), 32'h80000000, 32'h7fffffff, NO_CORRUPT, 1'b0);
        add_row(encode(OP_MIN, 12, 13, 14), 32'h0, 32'h0, NO_CORRUPT, 1'b1);
        add_row(encode(OP_MAXU, 12, 13, 14), 32'h0, 32'h0, NO_CORRUPT, 1'b1);
        // One broken field per row.
        add_row(encode(OP_SEXTH, 3, 4, 0), 32'h0000f00f, 32'h0, FLD_RD_WDATA, 1'b0);
        add_row(encode(OP_MIN, 3, 4, 5), 32'h00000010, 32'h00000020, FLD_PC_WDATA, 1'b0);
        add_row(encode(OP_MAX, 3, 4, 5), 32'h80000001, 32'h00000002, FLD_TRAP, 1'b0);
        add_row(encode(OP_MINU, 7, 4, 5), 32'h00000003, 32'h90000000, FLD_RD_ADDR, 1'b0);
        add_row(encode(OP_SEXTB, 3, 4, 0), 32'h000000aa, 32'h0, FLD_RS1_ADDR, 1'b0);
        add_row(encode(OP_MAXU, 3, 4, 5), 32'h00000005, 32'h00000006, FLD_RS2_ADDR, 1'b0);
        add_row(encode(OP_SEXTB, 3, 4, 0), 32'h00000055, 32'h0, FLD_RS2_ADDR, 1'b0);
        // Neither checker claims an add, broken or not.
        add_row(encode(OP_ADD, 1, 2, 3), 32'h00000005, 32'h00000007, NO_CORRUPT, 1'b0);
        add_row(encode(OP_ADD, 1, 2, 3), 32'h00000005, 32'h00000007, FLD_RD_WDATA, 1'b0);
    endtask

    task automatic build_report(input insn_t insn, input xlen_t rs1, input xlen_t rs2,
                                input xlen_t pc, input int corrupt);
        logic  is_sext;
        logic  is_minmax;
        logic  less;
        int    shift;
        xlen_t result;
        is_sext = insn[6:0] == 7'h13 && insn[14:12] == 3'b001 && insn[31:25] == 7'h30
                  && (insn[24:20] == 5'd4 || insn[24:20] == 5'd5);
        is_minmax = insn[6:0] == 7'h33 && insn[14] && insn[31:25] == 7'h05;
        // Bit 12 selects the unsigned order, bit 13 selects max over min.
        if (insn[12]) begin
            less = rs1 < rs2;
        end else begin
            less = (rs1 ^ 32'h80000000) < (rs2 ^ 32'h80000000);
        end
        shift = insn[20] ? 16 : 24;
        if (is_sext) begin
            result = $signed(rs1 << shift) >>> shift;
        end else if (is_minmax) begin
            result = (less ^ insn[13]) ? rs1 : rs2;
        end else begin
            result = rs1 + rs2;
        end
        rep_rs1_addr = insn[19:15];
        rep_rs2_addr = is_sext ? 5'd0 : insn[24:20];
        rep_rd_addr  = insn[11:7];
        rep_rd_wdata = (rep_rd_addr == 5'd0) ? 32'h0 : result;
        rep_pc_wdata = pc + 32'd4;
        rep_trap     = 1'b0;
        exp_checked  = is_sext || is_minmax;
        exp_fields   = '0;
        if (exp_checked && corrupt != NO_CORRUPT) begin
            exp_fields[corrupt] = 1'b1;
        end
        case (corrupt)
            FLD_TRAP:     rep_trap = 1'b1;
            FLD_RS1_ADDR: rep_rs1_addr = rep_rs1_addr ^ 5'd1;
            FLD_RS2_ADDR: rep_rs2_addr = rep_rs2_addr ^ 5'd1;
            FLD_RD_ADDR:  rep_rd_addr = rep_rd_addr ^ 5'd1;
            FLD_RD_WDATA: rep_rd_wdata = rep_rd_wdata ^ 32'h00000100;
            FLD_PC_WDATA: rep_pc_wdata = rep_pc_wdata + 32'd4;
            default:      ;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic send_row(input int idx, input bit check_lat);
        xlen_t   rs1;
        xlen_t   rs2;
        xlen_t   pc;
        int      t;
        bit      accepted;
        expect_t entry;
        rs1 = row_rs1[idx];
        rs2 = row_rs2[idx];
        if (row_random[idx]) begin
            rs1 = lcg_next();
            rs2 = lcg_next();
        end
        pc = 32'h00001000 + 32'(idx * 4);
        build_report(row_insn[idx], rs1, rs2, pc, row_corrupt[idx]);
        in_valid       <= 1'b1;
        rvfi_insn      <= row_insn[idx];
        rvfi_pc_rdata  <= pc;
        rvfi_rs1_addr  <= rep_rs1_addr;
        rvfi_rs2_addr  <= rep_rs2_addr;
        rvfi_rs1_rdata <= rs1;
        rvfi_rs2_rdata <= rs2;
        rvfi_rd_addr   <= rep_rd_addr;
        rvfi_rd_wdata  <= rep_rd_wdata;
        rvfi_pc_wdata  <= rep_pc_wdata;
        rvfi_trap      <= rep_trap;
        t = 0;
        accepted = 1'b0;
        while (!accepted && t < TIMEOUT) begin
            @(posedge clock);
            t++;
            accepted = in_ready;
        end
        if (accepted) begin
            entry.row       = 8'(idx);
            entry.checked   = exp_checked;
            entry.fields    = exp_fields;
            entry.pc        = pc;
            entry.cycle     = 32'(cycle_count);
            entry.check_lat = check_lat;
            sb_q.push_back(entry);
            accept_count++;
        end else begin
            $display("Timeout: row %0d was never accepted, in_ready stayed low", idx);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // Holds the consumer off and watches the pipeline fill and the verdict hold.
    task automatic stall_verdicts();
        int          accepts_at_start;
        bit          have_hold;
        logic        hold_checked;
        field_mask_t hold_fields;
        xlen_t       hold_pc;
        verdict_ready <= 1'b0;
        accepts_at_start = accept_count;
        have_hold = 1'b0;
        repeat (STALL_CYCLES) begin
            @(posedge clock);
            if (verdict_valid && have_hold) begin
                check_value("verdict_checked", 32'(hold_checked), 32'(verdict_checked));
                check_value("verdict_fields", 32'(hold_fields), 32'(verdict_fields));
                check_value("verdict_pc", hold_pc, verdict_pc);
            end else if (verdict_valid) begin
                hold_checked = verdict_checked;
                hold_fields  = verdict_fields;
                hold_pc      = verdict_pc;
                have_hold    = 1'b1;
            end
        end
        check_value("in_ready", 32'd0, 32'(in_ready));
        assert (accept_count - accepts_at_start <= 2) else begin
            $display("%0d packets were accepted while the verdict was stalled",
                     accept_count - accepts_at_start);
            errors++;
        end
        verdict_ready <= 1'b1;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (sb_q.size() != 0 && t < TIMEOUT) begin
            @(posedge clock);
            t++;
        end
        if (sb_q.size() != 0) begin
            $display("Timeout: %0d verdicts never arrived", sb_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic end_run();
        $display("%0d verdicts checked, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // Scoreboard side. Every verdict taken must match the oldest accepted packet.
    initial begin
        expect_t entry;
        int      errs_before;
        int      latency;
        forever begin
            @(posedge clock);
            if (!rst && verdict_valid && verdict_ready) begin
                assert (sb_q.size() != 0) else begin
                    $display("A verdict arrived at %0t with no packet outstanding", $time);
                    errors++;
                end
                if (sb_q.size() != 0) begin
                    entry = sb_q.pop_front();
                    errs_before = errors;
                    latency = cycle_count - int'(entry.cycle);
                    check_value("verdict_checked", 32'(entry.checked), 32'(verdict_checked));
                    check_value("verdict_fields", 32'(entry.fields), 32'(verdict_fields));
                    check_value("verdict_pc", entry.pc, verdict_pc);
                    if (entry.check_lat) begin
                        assert (latency == 2) else begin
                            $display("Row %0d took %0d cycles to its verdict instead of 2",
                                     entry.row, latency);
                            errors++;
                        end
                    end
                    tests++;
                    $display("row %2d pc %h checked %0b fields %b  %s", entry.row,
                             verdict_pc, verdict_checked, verdict_fields,
                             (errors == errs_before) ? "ok" : "bad");
                end
            end
        end
    end

    initial begin
        int i;
        rst            = 1'b1;
        in_valid       = 1'b0;
        rvfi_insn      = '0;
        rvfi_pc_rdata  = '0;
        rvfi_rs1_addr  = '0;
        rvfi_rs2_addr  = '0;
        rvfi_rs1_rdata = '0;
        rvfi_rs2_rdata = '0;
        rvfi_rd_addr   = '0;
        rvfi_rd_wdata  = '0;
        rvfi_pc_wdata  = '0;
        rvfi_trap      = 1'b0;
        verdict_ready  = 1'b1;
        load_table();
        repeat (16) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        check_value("in_ready", 32'd1, 32'(in_ready));
        check_value("verdict_valid", 32'd0, 32'(verdict_valid));

        // Back to back with the consumer always ready, so latency is checked.
        for (i = 0; i < n_rows; i++) begin
            if (!timed_out) begin
                send_row(i, 1'b1);
            end
        end
        in_valid <= 1'b0;
        if (!timed_out) begin
            wait_drain();
        end

        // Same table again with the consumer stalled at the start.
        if (!timed_out) begin
            fork
                begin
                    for (i = 0; i < n_rows; i++) begin
                        if (!timed_out) begin
                            send_row(i, 1'b0);
                        end
                    end
                    in_valid <= 1'b0;
                end
                stall_verdicts();
            join
            wait_drain();
        end
        repeat (4) @(posedge clock);
        assert (tests == 2 * n_rows) else begin
            $display("Expected %0d verdicts but took %0d", 2 * n_rows, tests);
            errors++;
        end
        end_run();
    end

endmodule

`default_nettype wire

// ==== logic/rvfi_insn_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

// Retirement monitor. Packets pass the retire buffer, are checked by the
// sext and min/max checkers and end up as one registered verdict each.
module rvfi_insn_monitor import rvfi_check_pkg::*; (
    input  wire         clock,
    input  wire         rst,

    input  wire         in_valid,
    output logic        in_ready,
    input  insn_t       rvfi_insn,
    input  xlen_t       rvfi_pc_rdata,
    input  reg_addr_t   rvfi_rs1_addr,
    input  reg_addr_t   rvfi_rs2_addr,
    input  xlen_t       rvfi_rs1_rdata,
    input  xlen_t       rvfi_rs2_rdata,
    input  reg_addr_t   rvfi_rd_addr,
    input  xlen_t       rvfi_rd_wdata,
    input  xlen_t       rvfi_pc_wdata,
    input  wire         rvfi_trap,

    output logic        verdict_valid,
    input  wire         verdict_ready,
    output logic        verdict_checked,
    output field_mask_t verdict_fields,
    output xlen_t       verdict_pc
);

    logic      buf_valid;
    logic      buf_ready;
    insn_t     buf_insn;
    xlen_t     buf_pc_rdata;
    reg_addr_t buf_rs1_addr;
    reg_addr_t buf_rs2_addr;
    xlen_t     buf_rs1_rdata;
    xlen_t     buf_rs2_rdata;
    reg_addr_t buf_rd_addr;
    xlen_t     buf_rd_wdata;
    xlen_t     buf_pc_wdata;
    logic      buf_trap;

    logic      sext_spec_valid;
    logic      sext_spec_trap;
    reg_addr_t sext_spec_rs1_addr;
    reg_addr_t sext_spec_rs2_addr;
    reg_addr_t sext_spec_rd_addr;
    xlen_t     sext_spec_rd_wdata;
    xlen_t     sext_spec_pc_wdata;

    logic      minmax_spec_valid;
    logic      minmax_spec_trap;
    reg_addr_t minmax_spec_rs1_addr;
    reg_addr_t minmax_spec_rs2_addr;
    reg_addr_t minmax_spec_rd_addr;
    xlen_t     minmax_spec_rd_wdata;
    xlen_t     minmax_spec_pc_wdata;

    rvfi_retire_buffer u_buffer (
        .clock          (clock),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .rvfi_insn      (rvfi_insn),
        .rvfi_pc_rdata  (rvfi_pc_rdata),
        .rvfi_rs1_addr  (rvfi_rs1_addr),
        .rvfi_rs2_addr  (rvfi_rs2_addr),
        .rvfi_rs1_rdata (rvfi_rs1_rdata),
        .rvfi_rs2_rdata (rvfi_rs2_rdata),
        .rvfi_rd_addr   (rvfi_rd_addr),
        .rvfi_rd_wdata  (rvfi_rd_wdata),
        .rvfi_pc_wdata  (rvfi_pc_wdata),
        .rvfi_trap      (rvfi_trap),
        .buf_valid      (buf_valid),
        .buf_ready      (buf_ready),
        .buf_insn       (buf_insn),
        .buf_pc_rdata   (buf_pc_rdata),
        .buf_rs1_addr   (buf_rs1_addr),
        .buf_rs2_addr   (buf_rs2_addr),
        .buf_rs1_rdata  (buf_rs1_rdata),
        .buf_rs2_rdata  (buf_rs2_rdata),
        .buf_rd_addr    (buf_rd_addr),
        .buf_rd_wdata   (buf_rd_wdata),
        .buf_pc_wdata   (buf_pc_wdata),
        .buf_trap       (buf_trap)
    );

    insn_sext_checker u_sext (
        .rvfi_valid     (buf_valid),
        .rvfi_insn      (buf_insn),
        .rvfi_pc_rdata  (buf_pc_rdata),
        .rvfi_rs1_rdata (buf_rs1_rdata),
        .spec_valid     (sext_spec_valid),
        .spec_trap      (sext_spec_trap),
        .spec_rs1_addr  (sext_spec_rs1_addr),
        .spec_rs2_addr  (sext_spec_rs2_addr),
        .spec_rd_addr   (sext_spec_rd_addr),
        .spec_rd_wdata  (sext_spec_rd_wdata),
        .spec_pc_wdata  (sext_spec_pc_wdata)
    );

    insn_minmax_checker u_minmax (
        .rvfi_valid     (buf_valid),
        .rvfi_insn      (buf_insn),
        .rvfi_pc_rdata  (buf_pc_rdata),
        .rvfi_rs1_rdata (buf_rs1_rdata),
        .rvfi_rs2_rdata (buf_rs2_rdata),
        .spec_valid     (minmax_spec_valid),
        .spec_trap      (minmax_spec_trap),
        .spec_rs1_addr  (minmax_spec_rs1_addr),
        .spec_rs2_addr  (minmax_spec_rs2_addr),
        .spec_rd_addr   (minmax_spec_rd_addr),
        .spec_rd_wdata  (minmax_spec_rd_wdata),
        .spec_pc_wdata  (minmax_spec_pc_wdata)
    );

    spec_compare u_compare (
        .clock                (clock),
        .rst                  (rst),
        .buf_valid            (buf_valid),
        .buf_ready            (buf_ready),
        .buf_pc_rdata         (buf_pc_rdata),
        .buf_rs1_addr         (buf_rs1_addr),
        .buf_rs2_addr         (buf_rs2_addr),
        .buf_rd_addr          (buf_rd_addr),
        .buf_rd_wdata         (buf_rd_wdata),
        .buf_pc_wdata         (buf_pc_wdata),
        .buf_trap             (buf_trap),
        .sext_spec_valid      (sext_spec_valid),
        .sext_spec_trap       (sext_spec_trap),
        .sext_spec_rs1_addr   (sext_spec_rs1_addr),
        .sext_spec_rs2_addr   (sext_spec_rs2_addr),
        .sext_spec_rd_addr    (sext_spec_rd_addr),
        .sext_spec_rd_wdata   (sext_spec_rd_wdata),
        .sext_spec_pc_wdata   (sext_spec_pc_wdata),
        .minmax_spec_valid    (minmax_spec_valid),
        .minmax_spec_trap     (minmax_spec_trap),
        .minmax_spec_rs1_addr (minmax_spec_rs1_addr),
        .minmax_spec_rs2_addr (minmax_spec_rs2_addr),
        .minmax_spec_rd_addr  (minmax_spec_rd_addr),
        .minmax_spec_rd_wdata (minmax_spec_rd_wdata),
        .minmax_spec_pc_wdata (minmax_spec_pc_wdata),
        .verdict_valid        (verdict_valid),
        .verdict_ready        (verdict_ready),
        .verdict_checked      (verdict_checked),
        .verdict_fields       (verdict_fields),
        .verdict_pc           (verdict_pc)
    );

endmodule

`default_nettype wire

// ==== logic/spec_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

// Merges the checker results, compares them against the buffered report and
// holds one verdict per packet until the consumer takes it.
module spec_compare import rvfi_check_pkg::*; (
    input  wire         clock,
    input  wire         rst,

    input  wire         buf_valid,
    output logic        buf_ready,
    input  xlen_t       buf_pc_rdata,
    input  reg_addr_t   buf_rs1_addr,
    input  reg_addr_t   buf_rs2_addr,
    input  reg_addr_t   buf_rd_addr,
    input  xlen_t       buf_rd_wdata,
    input  xlen_t       buf_pc_wdata,
    input  wire         buf_trap,

    input  wire         sext_spec_valid,
    input  wire         sext_spec_trap,
    input  reg_addr_t   sext_spec_rs1_addr,
    input  reg_addr_t   sext_spec_rs2_addr,
    input  reg_addr_t   sext_spec_rd_addr,
    input  xlen_t       sext_spec_rd_wdata,
    input  xlen_t       sext_spec_pc_wdata,

    input  wire         minmax_spec_valid,
    input  wire         minmax_spec_trap,
    input  reg_addr_t   minmax_spec_rs1_addr,
    input  reg_addr_t   minmax_spec_rs2_addr,
    input  reg_addr_t   minmax_spec_rd_addr,
    input  xlen_t       minmax_spec_rd_wdata,
    input  xlen_t       minmax_spec_pc_wdata,

    output logic        verdict_valid,
    input  wire         verdict_ready,
    output logic        verdict_checked,
    output field_mask_t verdict_fields,
    output xlen_t       verdict_pc
);

    logic        checked;
    logic        spec_trap;
    reg_addr_t   spec_rs1_addr;
    reg_addr_t   spec_rs2_addr;
    reg_addr_t   spec_rd_addr;
    xlen_t       spec_rd_wdata;
    xlen_t       spec_pc_wdata;
    field_mask_t fields;

    assign checked = sext_spec_valid || minmax_spec_valid;

    // The decoders are disjoint, so the sext result wins only when it is valid.
    assign spec_trap     = sext_spec_valid ? sext_spec_trap     : minmax_spec_trap;
    assign spec_rs1_addr = sext_spec_valid ? sext_spec_rs1_addr : minmax_spec_rs1_addr;
    assign spec_rs2_addr = sext_spec_valid ? sext_spec_rs2_addr : minmax_spec_rs2_addr;
    assign spec_rd_addr  = sext_spec_valid ? sext_spec_rd_addr  : minmax_spec_rd_addr;
    assign spec_rd_wdata = sext_spec_valid ? sext_spec_rd_wdata : minmax_spec_rd_wdata;
    assign spec_pc_wdata = sext_spec_valid ? sext_spec_pc_wdata : minmax_spec_pc_wdata;

    always_comb begin
        fields = '0;
        if (checked) begin
            fields[FLD_TRAP]     = spec_trap != buf_trap;
            fields[FLD_RS1_ADDR] = spec_rs1_addr != buf_rs1_addr;
            fields[FLD_RS2_ADDR] = spec_rs2_addr != buf_rs2_addr;
            fields[FLD_RD_ADDR]  = spec_rd_addr != buf_rd_addr;
            fields[FLD_RD_WDATA] = spec_rd_wdata != buf_rd_wdata;
            fields[FLD_PC_WDATA] = spec_pc_wdata != buf_pc_wdata;
        end
    end

    assign buf_ready = !verdict_valid || verdict_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            verdict_valid <= 1'b0;
        end else if (buf_ready) begin
            verdict_valid <= buf_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (buf_valid && buf_ready) begin
            verdict_checked <= checked;
            verdict_fields  <= fields;
            verdict_pc      <= buf_pc_rdata;
        end
    end

    // Overlapping encodings in the two checkers would make the merge ambiguous.
    a_one_spec: assert property (@(posedge clock) disable iff (rst)
        !(sext_spec_valid && minmax_spec_valid))
        else $error("both checkers claimed the same instruction");

    a_verdict_hold: assert property (@(posedge clock) disable iff (rst)
        verdict_valid && !verdict_ready |=> verdict_valid
            && $stable(verdict_checked) && $stable(verdict_fields)
            && $stable(verdict_pc))
        else $error("verdict changed while the consumer was stalled");

endmodule

`default_nettype wire

// ==== logic/insn_minmax_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Specification of the Zbb min, minu, max and maxu instructions.
module insn_minmax_checker import rvfi_check_pkg::*; (
    input  wire         rvfi_valid,
    input  insn_t       rvfi_insn,
    input  xlen_t       rvfi_pc_rdata,
    input  xlen_t       rvfi_rs1_rdata,
    input  xlen_t       rvfi_rs2_rdata,

    output logic        spec_valid,
    output logic        spec_trap,
    output reg_addr_t   spec_rs1_addr,
    output reg_addr_t   spec_rs2_addr,
    output reg_addr_t   spec_rd_addr,
    output xlen_t       spec_rd_wdata,
    output xlen_t       spec_pc_wdata
);

    logic  dec_min;
    logic  dec_minu;
    logic  dec_max;
    logic  dec_maxu;
    logic  lt_signed;
    logic  lt_unsigned;
    xlen_t result;

    assign dec_min  = rvfi_valid && ((rvfi_insn & MINMAX_MASK) == MIN_MATCH);
    assign dec_minu = rvfi_valid && ((rvfi_insn & MINMAX_MASK) == MINU_MATCH);
    assign dec_max  = rvfi_valid && ((rvfi_insn & MINMAX_MASK) == MAX_MATCH);
    assign dec_maxu = rvfi_valid && ((rvfi_insn & MINMAX_MASK) == MAXU_MATCH);

    assign spec_valid = dec_min || dec_minu || dec_max || dec_maxu;

    // The two orderings differ only when the operand sign bits differ.
    assign lt_signed   = $signed(rvfi_rs1_rdata) < $signed(rvfi_rs2_rdata);
    assign lt_unsigned = rvfi_rs1_rdata < rvfi_rs2_rdata;

    always_comb begin
        result = '0;
        if (dec_min) begin
            result = lt_signed ? rvfi_rs1_rdata : rvfi_rs2_rdata;
        end else if (dec_minu) begin
            result = lt_unsigned ? rvfi_rs1_rdata : rvfi_rs2_rdata;
        end else if (dec_max) begin
            result = lt_signed ? rvfi_rs2_rdata : rvfi_rs1_rdata;
        end else if (dec_maxu) begin
            result = lt_unsigned ? rvfi_rs2_rdata : rvfi_rs1_rdata;
        end
    end

    // Plain ALU operations, so no trap is possible.
    assign spec_trap = 1'b0;

    assign spec_rs1_addr = rvfi_insn[19:15];
    assign spec_rs2_addr = rvfi_insn[24:20];
    assign spec_rd_addr  = rvfi_insn[11:7];

    // Writes to x0 are reported as zero.
    assign spec_rd_wdata = (spec_rd_addr != '0) ? result : '0;
    assign spec_pc_wdata = rvfi_pc_rdata + 32'd4;

endmodule

`default_nettype wire

// ==== logic/insn_sext_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Specification of the Zbb sext.b and sext.h instructions.
module insn_sext_checker import rvfi_check_pkg::*; (
    input  wire         rvfi_valid,
    input  insn_t       rvfi_insn,
    input  xlen_t       rvfi_pc_rdata,
    input  xlen_t       rvfi_rs1_rdata,

    output logic        spec_valid,
    output logic        spec_trap,
    output reg_addr_t   spec_rs1_addr,
    output reg_addr_t   spec_rs2_addr,
    output reg_addr_t   spec_rd_addr,
    output xlen_t       spec_rd_wdata,
    output xlen_t       spec_pc_wdata
);

    logic  dec_sextb;
    logic  dec_sexth;
    xlen_t result_sextb;
    xlen_t result_sexth;
    xlen_t result;

    assign dec_sextb = rvfi_valid && ((rvfi_insn & SEXT_MASK) == SEXTB_MATCH);
    assign dec_sexth = rvfi_valid && ((rvfi_insn & SEXT_MASK) == SEXTH_MATCH);

    assign spec_valid = dec_sextb || dec_sexth;

    assign result_sextb = {{24{rvfi_rs1_rdata[7]}}, rvfi_rs1_rdata[7:0]};
    assign result_sexth = {{16{rvfi_rs1_rdata[15]}}, rvfi_rs1_rdata[15:0]};

    // At most one decode line is high, so an AND-OR select is enough.
    assign result = ({XLEN{dec_sextb}} & result_sextb)
                  | ({XLEN{dec_sexth}} & result_sexth);

    // Neither instruction can raise an exception.
    assign spec_trap = 1'b0;

    assign spec_rs1_addr = rvfi_insn[19:15];
    assign spec_rs2_addr = '0;
    assign spec_rd_addr  = rvfi_insn[11:7];

    // Writes to x0 are reported as zero.
    assign spec_rd_wdata = (spec_rd_addr != '0) ? result : '0;
    assign spec_pc_wdata = rvfi_pc_rdata + 32'd4;

endmodule

`default_nettype wire

// ==== logic/rvfi_retire_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// One-entry register stage in front of the checkers. A new packet is taken
// when the stage is empty or its current packet drains in the same cycle.
module rvfi_retire_buffer import rvfi_check_pkg::*; (
    input  wire         clock,
    input  wire         rst,

    input  wire         in_valid,
    output logic        in_ready,
    input  insn_t       rvfi_insn,
    input  xlen_t       rvfi_pc_rdata,
    input  reg_addr_t   rvfi_rs1_addr,
    input  reg_addr_t   rvfi_rs2_addr,
    input  xlen_t       rvfi_rs1_rdata,
    input  xlen_t       rvfi_rs2_rdata,
    input  reg_addr_t   rvfi_rd_addr,
    input  xlen_t       rvfi_rd_wdata,
    input  xlen_t       rvfi_pc_wdata,
    input  wire         rvfi_trap,

    output logic        buf_valid,
    input  wire         buf_ready,
    output insn_t       buf_insn,
    output xlen_t       buf_pc_rdata,
    output reg_addr_t   buf_rs1_addr,
    output reg_addr_t   buf_rs2_addr,
    output xlen_t       buf_rs1_rdata,
    output xlen_t       buf_rs2_rdata,
    output reg_addr_t   buf_rd_addr,
    output xlen_t       buf_rd_wdata,
    output xlen_t       buf_pc_wdata,
    output logic        buf_trap
);

    assign in_ready = !buf_valid || buf_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (in_ready) begin
            buf_valid <= in_valid;
        end
    end

    // The packet itself only moves on an accepted transfer.
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            buf_insn      <= rvfi_insn;
            buf_pc_rdata  <= rvfi_pc_rdata;
            buf_rs1_addr  <= rvfi_rs1_addr;
            buf_rs2_addr  <= rvfi_rs2_addr;
            buf_rs1_rdata <= rvfi_rs1_rdata;
            buf_rs2_rdata <= rvfi_rs2_rdata;
            buf_rd_addr   <= rvfi_rd_addr;
            buf_rd_wdata  <= rvfi_rd_wdata;
            buf_pc_wdata  <= rvfi_pc_wdata;
            buf_trap      <= rvfi_trap;
        end
    end

    // A stalled packet must reach the compare stage unchanged.
    a_hold_stable: assert property (@(posedge clock) disable iff (rst)
        buf_valid && !buf_ready |=> buf_valid && $stable(buf_insn)
            && $stable(buf_pc_rdata) && $stable(buf_rs1_addr)
            && $stable(buf_rs2_addr) && $stable(buf_rs1_rdata)
            && $stable(buf_rs2_rdata) && $stable(buf_rd_addr)
            && $stable(buf_rd_wdata) && $stable(buf_pc_wdata)
            && $stable(buf_trap))
        else $error("retire buffer changed a stalled packet");

endmodule

`default_nettype wire

// ==== logic/rvfi_check_pkg.sv ====
`default_nettype none

package rvfi_check_pkg;

    // Architectural widths of the monitored core.
    localparam int XLEN = 32;
    localparam int ILEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] insn_t;
    typedef logic [4:0]      reg_addr_t;

    // One bit per reported field that can disagree with the specification.
    typedef logic [5:0]      field_mask_t;

    localparam int FLD_TRAP     = 0;
    localparam int FLD_RS1_ADDR = 1;
    localparam int FLD_RS2_ADDR = 2;
    localparam int FLD_RD_ADDR  = 3;
    localparam int FLD_RD_WDATA = 4;
    localparam int FLD_PC_WDATA = 5;

    // Unary Zbb encodings; funct12 and funct3 select the operation.
    localparam insn_t SEXT_MASK   = 32'hfff0707f;
    localparam insn_t SEXTB_MATCH = 32'h60401013;
    localparam insn_t SEXTH_MATCH = 32'h60501013;

    // Register-register Zbb min/max; funct7 and funct3 select the operation.
    localparam insn_t MINMAX_MASK = 32'hfe00707f;
    localparam insn_t MIN_MATCH   = 32'h0a004033;
    localparam insn_t MINU_MATCH  = 32'h0a005033;
    localparam insn_t MAX_MATCH   = 32'h0a006033;
    localparam insn_t MAXU_MATCH  = 32'h0a007033;

endpackage

`default_nettype wire
